// File: operand_top.f
+incdir+common
common/rv_pkg.sv
hw/operand/reg_decode.sv
hw/operand/reg_file.sv
hw/operand/hazard_unit.sv
hw/operand/operand_issue.sv
hw/operand/operand_top.sv
dv/tb_clock.sv
dv/operand_assert.sv
dv/operand_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the operand stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module operand_tb -f operand_top.f \
	-Mdir build -o operand_sim
./build/operand_sim

// File: dv/operand_tb.sv
// ##########################################################
// operand stage testbench
// register mirror, forwarding and load stall scenarios
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module operand_tb;

	localparam int WAIT_LIMIT = 50;

	logic clock, reset;
	logic instr_valid_i;
	logic [`RV_XLEN-1:0] instr_i;
	logic exu_ready_i, exu_wd_i, exu_load_i;
	rv_pkg::reg_idx_t exu_rd_i;
	logic [`RV_XLEN-1:0] exu_wdata_i;
	logic lsu_ready_i, lsu_wd_i, lsu_load_i, lsu_valid_i;
	rv_pkg::reg_idx_t lsu_rd_i;
	logic [`RV_XLEN-1:0] lsu_wdata_i;
	logic wb_we_i;
	rv_pkg::reg_idx_t wb_rd_i;
	logic [`RV_XLEN-1:0] wb_data_i;
	logic issue_o, rd_we_o, stall_o;
	logic [`RV_XLEN-1:0] op_a_o, op_b_o;
	rv_pkg::reg_idx_t rd_o;

	// expected register contents, x0 stays zero
	logic [`RV_XLEN-1:0] mirror [0:`RV_NREGS-1];
	integer seed;

	tb_clock u_clock (.clock_o(clock), .reset_o(reset));

	operand_top dut0 (.*);

	bind operand_top operand_assert u_assert (
		.clock(clock), .reset(reset), .instr_valid_i(instr_valid_i),
		.pend_i(pend), .issue_i(issue_o), .stall_i(stall_o)
	);

	// fields placed by position, so I, S and LUI reuse the R slots
	function automatic logic [`RV_XLEN-1:0] make_instr(input logic [6:0] opcode,
		input rv_pkg::reg_idx_t rd, input rv_pkg::reg_idx_t rs1, input rv_pkg::reg_idx_t rs2);
		rv_pkg::instr_u w;
		w.r.funct7 = 7'h00;
		w.r.rs2 = rs2;
		w.r.rs1 = rs1;
		w.r.funct3 = 3'b000;
		w.r.rd = rd;
		w.r.opcode = opcode;
		make_instr = w;
	endfunction

	function automatic logic [6:0] opcode_of(input int k);
		case (k % 5)
			0: opcode_of = `RV_OP_REG;
			1: opcode_of = `RV_OP_IMM;
			2: opcode_of = `RV_OP_LOAD;
			3: opcode_of = `RV_OP_STORE;
			default: opcode_of = `RV_OP_LUI;
		endcase
	endfunction

	// newest producer first, loads only once their data is back
	function automatic logic [`RV_XLEN-1:0] model_operand(input logic ren,
		input rv_pkg::reg_idx_t rs);
		logic live;
		live = ren && (rs != 5'd0);
		if (live && !exu_ready_i && exu_wd_i && (exu_rd_i == rs)) begin
			model_operand = exu_wdata_i;
		end else if (live && !lsu_ready_i && lsu_wd_i && (lsu_rd_i == rs)
			&& (!lsu_load_i || lsu_valid_i)) begin
			model_operand = lsu_wdata_i;
		end else begin
			model_operand = mirror[rs];
		end
	endfunction

	function automatic logic [`RV_XLEN-1:0] model_a(input logic [`RV_XLEN-1:0] word);
		rv_pkg::instr_u w;
		w = word;
		model_a = model_operand(w.i.opcode != `RV_OP_LUI, w.i.rs1);
	endfunction

	function automatic logic [`RV_XLEN-1:0] model_b(input logic [`RV_XLEN-1:0] word);
		rv_pkg::instr_u w;
		w = word;
		model_b = model_operand((w.r.opcode == `RV_OP_REG) || (w.r.opcode == `RV_OP_STORE),
			w.r.rs2);
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "operand stage run stopped");
	endtask

	task automatic expect_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic write_reg(input rv_pkg::reg_idx_t idx, input logic [`RV_XLEN-1:0] data);
		wb_we_i = 1'b1;
		wb_rd_i = idx;
		wb_data_i = data;
		if (idx != 5'd0) begin
			mirror[idx] = data;
		end
		@(negedge clock);
		wb_we_i = 1'b0;
	endtask

	task automatic send_instr(input logic [`RV_XLEN-1:0] word);
		instr_i = word;
		instr_valid_i = 1'b1;
		@(negedge clock);
		instr_valid_i = 1'b0;
	endtask

	// cycles counts falling edges since the strobe was driven
	task automatic wait_issue(output int cycles);
		cycles = 1;
		while (!issue_o) begin
			if (cycles >= WAIT_LIMIT) begin
				fail_run("timeout waiting for issue_o");
			end
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic hold_stall(input int n);
		repeat (n) begin
			assert (stall_o && !issue_o) else begin
				fail_run("stall_o dropped or issue_o rose while the hazard was held");
			end
			@(negedge clock);
		end
	endtask

	task automatic check_issue(input logic [`RV_XLEN-1:0] word, input logic [31:0] exp_a);
		rv_pkg::instr_u w;
		logic exp_we;
		w = word;
		exp_we = (w.i.opcode != `RV_OP_STORE) && (w.i.rd != 5'd0);
		expect_word("op_a_o", op_a_o, exp_a);
		expect_word("op_b_o", op_b_o, model_b(word));
		expect_word("rd_o", {27'd0, rd_o}, {27'd0, w.i.rd});
		expect_word("rd_we_o", {31'd0, rd_we_o}, {31'd0, exp_we});
	endtask

	task automatic send_plain(input logic [`RV_XLEN-1:0] word);
		int cycles;
		send_instr(word);
		wait_issue(cycles);
		expect_word("issue_o latency", cycles, 2);
		check_issue(word, model_a(word));
	endtask

	initial begin
		int cycles;
		logic [31:0] rnd, hold;
		logic [`RV_XLEN-1:0] word;
		seed = 32'h0d555944;
		instr_valid_i = 1'b0;
		instr_i = '0;
		exu_ready_i = 1'b1;
		exu_wd_i = 1'b0;
		exu_load_i = 1'b0;
		exu_rd_i = 5'd0;
		exu_wdata_i = '0;
		lsu_ready_i = 1'b1;
		lsu_wd_i = 1'b0;
		lsu_load_i = 1'b0;
		lsu_valid_i = 1'b0;
		lsu_rd_i = 5'd0;
		lsu_wdata_i = '0;
		wb_we_i = 1'b0;
		wb_rd_i = 5'd0;
		wb_data_i = '0;
		for (int i = 0; i < `RV_NREGS; i++) begin
			mirror[i] = '0;
		end

		// quiet through reset and the first cycle after it
		@(posedge clock);
		cycles = 0;
		do begin
			@(negedge clock);
			assert (!issue_o && !stall_o) else begin
				fail_run("issue_o or stall_o high around reset");
			end
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				fail_run("timeout waiting for reset release");
			end
		end while (reset);

		for (int i = 1; i < `RV_NREGS; i++) begin
			write_reg(rv_pkg::reg_idx_t'(i), $random(seed));
		end
		@(negedge clock);

		// no hazard, every form, x0 reads and x0 destination
		send_plain(make_instr(`RV_OP_REG, 5'd3, 5'd1, 5'd2));
		send_plain(make_instr(`RV_OP_REG, 5'd0, 5'd0, 5'd7));
		send_plain(make_instr(`RV_OP_IMM, 5'd9, 5'd4, 5'd5));
		send_plain(make_instr(`RV_OP_LOAD, 5'd11, 5'd6, 5'd0));
		send_plain(make_instr(`RV_OP_STORE, 5'd6, 5'd8, 5'd10));
		send_plain(make_instr(`RV_OP_LUI, 5'd12, 5'd13, 5'd14));
		for (int n = 0; n < 8; n++) begin
			rnd = $random(seed);
			send_plain(make_instr(opcode_of(int'(rnd[31:29])), rnd[4:0], rnd[9:5], rnd[14:10]));
		end

		// ALU results from EXU on rs1, LSU on rs2
		exu_ready_i = 1'b0;
		exu_wd_i = 1'b1;
		exu_rd_i = 5'd5;
		exu_wdata_i = $random(seed);
		lsu_ready_i = 1'b0;
		lsu_wd_i = 1'b1;
		lsu_rd_i = 5'd9;
		lsu_wdata_i = $random(seed);
		send_plain(make_instr(`RV_OP_REG, 5'd17, 5'd5, 5'd9));
		send_plain(make_instr(`RV_OP_REG, 5'd17, 5'd9, 5'd5));
		// unread rs2 slot of an I form must not pick up the bypass
		send_plain(make_instr(`RV_OP_IMM, 5'd17, 5'd1, 5'd5));
		// LUI reads neither slot
		send_plain(make_instr(`RV_OP_LUI, 5'd17, 5'd5, 5'd9));
		// both stages write x5, EXU is newer
		lsu_rd_i = 5'd5;
		send_plain(make_instr(`RV_OP_REG, 5'd18, 5'd5, 5'd5));
		exu_rd_i = 5'd0;
		send_plain(make_instr(`RV_OP_REG, 5'd18, 5'd0, 5'd0));
		exu_rd_i = 5'd9;
		exu_wd_i = 1'b0;
		send_plain(make_instr(`RV_OP_STORE, 5'd2, 5'd9, 5'd5));
		exu_ready_i = 1'b1;

		// load returning from LSU in the same cycle is forwarded
		lsu_load_i = 1'b1;
		lsu_rd_i = 5'd9;
		lsu_wdata_i = $random(seed);
		word = make_instr(`RV_OP_STORE, 5'd4, 5'd3, 5'd9);
		send_instr(word);
		lsu_valid_i = 1'b1;
		wait_issue(cycles);
		expect_word("issue_o latency", cycles, 2);
		check_issue(word, model_a(word));
		lsu_valid_i = 1'b0;
		lsu_ready_i = 1'b1;
		lsu_load_i = 1'b0;

		// load still in EXU holds the stage
		exu_ready_i = 1'b0;
		exu_wd_i = 1'b1;
		exu_load_i = 1'b1;
		exu_rd_i = 5'd21;
		word = make_instr(`RV_OP_REG, 5'd22, 5'd7, 5'd21);
		send_instr(word);
		hold_stall(5);
		exu_ready_i = 1'b1;
		wait_issue(cycles);
		check_issue(word, model_a(word));
		exu_load_i = 1'b0;

		// load in LSU, data captured at return
		lsu_ready_i = 1'b0;
		lsu_wd_i = 1'b1;
		lsu_load_i = 1'b1;
		lsu_rd_i = 5'd25;
		word = make_instr(`RV_OP_IMM, 5'd26, 5'd25, 5'd8);
		send_instr(word);
		hold_stall(4);
		hold = $random(seed);
		lsu_wdata_i = hold;
		lsu_valid_i = 1'b1;
		@(negedge clock);
		lsu_valid_i = 1'b0;
		lsu_wdata_i = ~hold;
		wait_issue(cycles);
		check_issue(word, hold);
		lsu_ready_i = 1'b1;
		lsu_load_i = 1'b0;

		@(negedge clock);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/operand_assert.sv
// ##########################################################
// protocol assertions for the operand stage
// issue strobe shape, strobe while pending, stall vs issue
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module operand_assert (
	input wire logic clock,
	input wire logic reset,
	input wire logic instr_valid_i,
	input wire logic pend_i,
	input wire logic issue_i,
	input wire logic stall_i
);

	// issue is a one-cycle strobe
	issue_single: assert property (@(posedge clock) disable iff (reset)
		issue_i |=> !issue_i)
		else $error("issue_o high in two consecutive cycles");

	// environment must wait for the held instruction to issue
	no_strobe_pending: assert property (@(posedge clock) disable iff (reset)
		instr_valid_i |-> !pend_i)
		else $error("instr_valid_i strobed while an instruction is pending");

	// stall never overlaps the issue strobe
	stall_clear_at_issue: assert property (@(posedge clock) disable iff (reset)
		issue_i |-> !stall_i)
		else $error("stall_o high while issue_o is high");

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
// ##########################################################
// testbench clock and reset source
// 4 ns clock, reset held for the first 16 cycles
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clock_o,
	output logic reset_o
);

	initial begin
		clock_o = 1'b0;
		forever #2 clock_o = ~clock_o;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset_o = 1'b1;
		repeat (16) @(posedge clock_o);
		@(negedge clock_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

// File: hw/operand/operand_top.sv
// ##########################################################
// operand stage of the rv32i pipeline
// decode, register read, hazard resolution and issue
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module operand_top (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                instr_valid_i,
	input  wire logic [`RV_XLEN-1:0] instr_i,
	input  wire logic                exu_ready_i,
	input  wire logic                exu_wd_i,
	input  wire logic                exu_load_i,
	input  wire rv_pkg::reg_idx_t    exu_rd_i,
	input  wire logic [`RV_XLEN-1:0] exu_wdata_i,
	input  wire logic                lsu_ready_i,
	input  wire logic                lsu_wd_i,
	input  wire logic                lsu_load_i,
	input  wire logic                lsu_valid_i,
	input  wire rv_pkg::reg_idx_t    lsu_rd_i,
	input  wire logic [`RV_XLEN-1:0] lsu_wdata_i,
	input  wire logic                wb_we_i,
	input  wire rv_pkg::reg_idx_t    wb_rd_i,
	input  wire logic [`RV_XLEN-1:0] wb_data_i,
	output logic                     issue_o,
	output logic [`RV_XLEN-1:0]      op_a_o,
	output logic [`RV_XLEN-1:0]      op_b_o,
	output rv_pkg::reg_idx_t         rd_o,
	output logic                     rd_we_o,
	output logic                     stall_o
);

	logic pend;
	logic issue_go;
	logic ren1, ren2, wd;
	rv_pkg::reg_idx_t rs1, rs2, dec_rd;
	logic [`RV_XLEN-1:0] rdata_a, rdata_b;
	logic fwd_a, fwd_b;
	logic [`RV_XLEN-1:0] bypass_a, bypass_b;

	// issue event seen by decode, same condition as in operand_issue
	assign issue_go = pend & ~stall_o;

	reg_decode u_decode (
		.clock(clock), .reset(reset),
		.instr_valid_i(instr_valid_i), .instr_i(instr_i), .issue_i(issue_go),
		.pend_o(pend), .rs1_o(rs1), .rs2_o(rs2), .ren1_o(ren1), .ren2_o(ren2),
		.rd_o(dec_rd), .wd_o(wd)
	);

	reg_file u_regs (
		.clock(clock), .reset(reset),
		.we_i(wb_we_i), .waddr_i(wb_rd_i), .wdata_i(wb_data_i),
		.raddr_a_i(rs1), .raddr_b_i(rs2),
		.rdata_a_o(rdata_a), .rdata_b_o(rdata_b)
	);

	hazard_unit u_hazard (
		.clock(clock), .reset(reset),
		.pend_i(pend), .ren1_i(ren1), .ren2_i(ren2), .rs1_i(rs1), .rs2_i(rs2),
		.exu_ready_i(exu_ready_i), .exu_wd_i(exu_wd_i), .exu_load_i(exu_load_i),
		.exu_rd_i(exu_rd_i), .exu_wdata_i(exu_wdata_i),
		.lsu_ready_i(lsu_ready_i), .lsu_wd_i(lsu_wd_i), .lsu_load_i(lsu_load_i),
		.lsu_valid_i(lsu_valid_i), .lsu_rd_i(lsu_rd_i), .lsu_wdata_i(lsu_wdata_i),
		.fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .bypass_a_o(bypass_a), .bypass_b_o(bypass_b),
		.stall_o(stall_o)
	);

	operand_issue u_issue (
		.clock(clock), .reset(reset),
		.pend_i(pend), .stall_i(stall_o),
		.fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .bypass_a_i(bypass_a), .bypass_b_i(bypass_b),
		.rdata_a_i(rdata_a), .rdata_b_i(rdata_b), .rd_i(dec_rd), .wd_i(wd),
		.issue_o(issue_o), .op_a_o(op_a_o), .op_b_o(op_b_o), .rd_o(rd_o), .rd_we_o(rd_we_o)
	);

endmodule

`default_nettype wire

// File: hw/operand/operand_issue.sv
// ##########################################################
// operand issue register
// picks bypass or register data and launches to execute
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module operand_issue (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                pend_i,
	input  wire logic                stall_i,
	input  wire logic                fwd_a_i,
	input  wire logic                fwd_b_i,
	input  wire logic [`RV_XLEN-1:0] bypass_a_i,
	input  wire logic [`RV_XLEN-1:0] bypass_b_i,
	input  wire logic [`RV_XLEN-1:0] rdata_a_i,
	input  wire logic [`RV_XLEN-1:0] rdata_b_i,
	input  wire rv_pkg::reg_idx_t    rd_i,
	input  wire logic                wd_i,
	output logic                     issue_o,
	output logic [`RV_XLEN-1:0]      op_a_o,
	output logic [`RV_XLEN-1:0]      op_b_o,
	output rv_pkg::reg_idx_t         rd_o,
	output logic                     rd_we_o
);

	logic issue_ev;
	logic [`RV_XLEN-1:0] op_a_d, op_b_d;

	assign issue_ev = pend_i & ~stall_i;
	assign op_a_d   = fwd_a_i ? bypass_a_i : rdata_a_i;
	assign op_b_d   = fwd_b_i ? bypass_b_i : rdata_b_i;

	// one-cycle strobe after the issuing edge
	always_ff @(posedge clock) begin
		if (reset) begin
			issue_o <= 1'b0;
			rd_we_o <= 1'b0;
		end else begin
			issue_o <= issue_ev;
			if (issue_ev) begin
				rd_we_o <= wd_i;
			end
		end
	end

	// operands stay put until the next issue
	always_ff @(posedge clock) begin
		if (issue_ev) begin
			op_a_o <= op_a_d;
			op_b_o <= op_b_d;
			rd_o   <= rd_i;
		end
	end

endmodule

`default_nettype wire

// File: hw/operand/hazard_unit.sv
// ##########################################################
// read-after-write hazard unit
// per-operand forwarding from EXU and LSU, load stall
// with wait state and captured load return data
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module hazard_unit (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                pend_i,
	input  wire logic                ren1_i,
	input  wire logic                ren2_i,
	input  wire rv_pkg::reg_idx_t    rs1_i,
	input  wire rv_pkg::reg_idx_t    rs2_i,
	input  wire logic                exu_ready_i,
	input  wire logic                exu_wd_i,
	input  wire logic                exu_load_i,
	input  wire rv_pkg::reg_idx_t    exu_rd_i,
	input  wire logic [`RV_XLEN-1:0] exu_wdata_i,
	input  wire logic                lsu_ready_i,
	input  wire logic                lsu_wd_i,
	input  wire logic                lsu_load_i,
	input  wire logic                lsu_valid_i,
	input  wire rv_pkg::reg_idx_t    lsu_rd_i,
	input  wire logic [`RV_XLEN-1:0] lsu_wdata_i,
	output logic                     fwd_a_o,
	output logic                     fwd_b_o,
	output logic [`RV_XLEN-1:0]      bypass_a_o,
	output logic [`RV_XLEN-1:0]      bypass_b_o,
	output logic                     stall_o
);

	localparam logic ST_RUN      = 1'b0;
	localparam logic ST_WAIT_LSU = 1'b1;

	logic state_q, state_d;
	logic cap_vld_q;
	rv_pkg::reg_idx_t cap_rd_q;
	logic [`RV_XLEN-1:0] cap_data_q;
	logic rd_a, rd_b, run;
	logic exu_hit_a, exu_hit_b, lsu_hit_a, lsu_hit_b, cap_hit_a, cap_hit_b;
	logic exu_load_stall, lsu_wait_a, lsu_wait_b, lsu_load_wait;
	logic lsu_ok, cap_en, issue_ev;
	logic [`RV_XLEN:0] sel_a, sel_b;

	// source matches a live, nonzero producer destination
	function automatic logic src_hit(
		input logic             ren,
		input rv_pkg::reg_idx_t rs,
		input logic             busy,
		input logic             wd,
		input rv_pkg::reg_idx_t rd
	);
		src_hit = ren && (rs != '0) && (rs == rd) && wd && busy;
	endfunction

	// returns {use bypass, data}, newest producer first
	function automatic logic [`RV_XLEN:0] pick(
		input logic                use_exu,
		input logic                use_lsu,
		input logic                use_cap,
		input logic [`RV_XLEN-1:0] exu_d,
		input logic [`RV_XLEN-1:0] lsu_d,
		input logic [`RV_XLEN-1:0] cap_d
	);
		if (use_exu) begin
			pick = {1'b1, exu_d};
		end else if (use_lsu) begin
			pick = {1'b1, lsu_d};
		end else if (use_cap) begin
			pick = {1'b1, cap_d};
		end else begin
			pick = {1'b0, {`RV_XLEN{1'b0}}};
		end
	endfunction

	assign rd_a = pend_i & ren1_i;
	assign rd_b = pend_i & ren2_i;
	assign run  = (state_q == ST_RUN);

	assign exu_hit_a = src_hit(rd_a, rs1_i, ~exu_ready_i, exu_wd_i, exu_rd_i);
	assign exu_hit_b = src_hit(rd_b, rs2_i, ~exu_ready_i, exu_wd_i, exu_rd_i);
	assign lsu_hit_a = src_hit(rd_a, rs1_i, ~lsu_ready_i, lsu_wd_i, lsu_rd_i);
	assign lsu_hit_b = src_hit(rd_b, rs2_i, ~lsu_ready_i, lsu_wd_i, lsu_rd_i);
	assign cap_hit_a = src_hit(rd_a, rs1_i, cap_vld_q, 1'b1, cap_rd_q);
	assign cap_hit_b = src_hit(rd_b, rs2_i, cap_vld_q, 1'b1, cap_rd_q);

	// load still in EXU, nothing to forward yet
	assign exu_load_stall = (exu_hit_a | exu_hit_b) & exu_load_i;

	// load in LSU whose data has not come back and was not captured
	assign lsu_wait_a    = lsu_hit_a & lsu_load_i & ~lsu_valid_i & ~cap_hit_a;
	assign lsu_wait_b    = lsu_hit_b & lsu_load_i & ~lsu_valid_i & ~cap_hit_b;
	assign lsu_load_wait = lsu_wait_a | lsu_wait_b;

	assign stall_o  = ~run | exu_load_stall | lsu_load_wait;
	assign issue_ev = pend_i & ~stall_o;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_RUN: begin
				// EXU load takes precedence, keep checking in RUN
				if (!exu_load_stall && lsu_load_wait) begin
					state_d = ST_WAIT_LSU;
				end
			end
			default: begin
				if (lsu_valid_i) begin
					state_d = ST_RUN;
				end
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ST_RUN;
		end else begin
			state_q <= state_d;
		end
	end

	// grab returning load data the stage depends on
	assign cap_en = lsu_valid_i & (~run | lsu_hit_a | lsu_hit_b);

	always_ff @(posedge clock) begin
		if (reset) begin
			cap_vld_q <= 1'b0;
		end else if (issue_ev) begin
			cap_vld_q <= 1'b0;
		end else if (cap_en) begin
			cap_vld_q <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (cap_en) begin
			cap_rd_q   <= lsu_rd_i;
			cap_data_q <= lsu_wdata_i;
		end
	end

	// LSU data usable directly for non-loads or a load returning now
	assign lsu_ok = ~lsu_load_i | (lsu_valid_i & run);

	assign sel_a = pick(exu_hit_a & ~exu_load_i, lsu_hit_a & lsu_ok, cap_hit_a & run,
		exu_wdata_i, lsu_wdata_i, cap_data_q);
	assign sel_b = pick(exu_hit_b & ~exu_load_i, lsu_hit_b & lsu_ok, cap_hit_b & run,
		exu_wdata_i, lsu_wdata_i, cap_data_q);

	assign fwd_a_o    = sel_a[`RV_XLEN];
	assign bypass_a_o = sel_a[`RV_XLEN-1:0];
	assign fwd_b_o    = sel_b[`RV_XLEN];
	assign bypass_b_o = sel_b[`RV_XLEN-1:0];

endmodule

`default_nettype wire

// File: hw/operand/reg_file.sv
// ##########################################################
// integer register file
// two read ports, one write port, x0 reads as zero
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module reg_file (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                we_i,
	input  wire rv_pkg::reg_idx_t    waddr_i,
	input  wire logic [`RV_XLEN-1:0] wdata_i,
	input  wire rv_pkg::reg_idx_t    raddr_a_i,
	input  wire rv_pkg::reg_idx_t    raddr_b_i,
	output logic [`RV_XLEN-1:0]      rdata_a_o,
	output logic [`RV_XLEN-1:0]      rdata_b_o
);

	// x1..x31, x0 has no storage
	logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// no write-through, a written value is visible after the edge
	always_comb begin
		if (raddr_a_i == '0) begin
			rdata_a_o = '0;
		end else begin
			rdata_a_o = regs[raddr_a_i];
		end
	end

	always_comb begin
		if (raddr_b_i == '0) begin
			rdata_b_o = '0;
		end else begin
			rdata_b_o = regs[raddr_b_i];
		end
	end

endmodule

`default_nettype wire

// File: hw/operand/reg_decode.sv
// ##########################################################
// pending instruction holder and register decode
// sources, read enables and destination by opcode
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module reg_decode (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                instr_valid_i,
	input  wire logic [`RV_XLEN-1:0] instr_i,
	input  wire logic                issue_i,
	output logic                     pend_o,
	output rv_pkg::reg_idx_t         rs1_o,
	output rv_pkg::reg_idx_t         rs2_o,
	output logic                     ren1_o,
	output logic                     ren2_o,
	output rv_pkg::reg_idx_t         rd_o,
	output logic                     wd_o
);

	rv_pkg::instr_u instr_q;
	logic pend_q;
	logic is_reg, is_imm, is_load, is_store, is_lui;

	// instruction word, only meaningful while pending
	always_ff @(posedge clock) begin
		if (instr_valid_i) begin
			instr_q <= instr_i;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pend_q <= 1'b0;
		end else if (instr_valid_i) begin
			pend_q <= 1'b1;
		end else if (issue_i) begin
			pend_q <= 1'b0;
		end
	end

	assign is_reg   = (instr_q.r.opcode == `RV_OP_REG);
	assign is_imm   = (instr_q.i.opcode == `RV_OP_IMM);
	assign is_load  = (instr_q.i.opcode == `RV_OP_LOAD);
	assign is_store = (instr_q.i.opcode == `RV_OP_STORE);
	assign is_lui   = (instr_q.i.opcode == `RV_OP_LUI);

	assign pend_o = pend_q;
	assign rs1_o  = instr_q.i.rs1;
	assign rs2_o  = instr_q.r.rs2;
	assign rd_o   = instr_q.i.rd;

	// rs2 exists only in R and S shapes, LUI has no rs1
	assign ren1_o = is_reg | is_imm | is_load | is_store;
	assign ren2_o = is_reg | is_store;
	// stores carry imm bits where rd would be
	assign wd_o   = (is_reg | is_imm | is_load | is_lui) & (instr_q.i.rd != '0);

endmodule

`default_nettype wire

// File: common/rv_pkg.sv
// ##########################################################
// rv32i shared types for the operand stage
// register index and the two views of an instruction word
// ##########################################################
`default_nettype none

package rv_pkg;

	// architectural register index, x0..x31
	typedef logic [4:0] reg_idx_t;

	// one 32-bit instruction word decoded in two ways
	typedef union packed {
		// register-register form
		struct packed {
			logic [6:0] funct7;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			reg_idx_t   rd;
			logic [6:0] opcode;
		} r;
		// immediate shape, S stores keep imm[4:0] in the rd slot
		struct packed {
			logic [11:0] imm;
			reg_idx_t    rs1;
			logic [2:0]  funct3;
			reg_idx_t    rd;
			logic [6:0]  opcode;
		} i;
	} instr_u;

endpackage

`default_nettype wire

// File: common/rv_defines.svh
// ##########################################################
// rv32i constants for the operand stage
// data width, register count and major opcodes
// ##########################################################
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// integer data path width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// major opcodes, bits [6:0] of the instruction
`define RV_OP_REG   7'b0110011
`define RV_OP_IMM   7'b0010011
`define RV_OP_LOAD  7'b0000011
`define RV_OP_STORE 7'b0100011
`define RV_OP_LUI   7'b0110111

`endif
